// File: src/led_ctrl_config.svh
`ifndef LED_CTRL_CONFIG_SVH
`define LED_CTRL_CONFIG_SVH

// uart bit timing in clk_in cycles
`define LED_UART_TICKS_PER_BIT 16
// wide enough to hold ticks per bit minus one
`define LED_UART_TICKS_WIDTH 5

// frame buffer geometry, 32 rows of 128 bytes
`define LED_ROW_BITS 5
`define LED_COL_BYTES 128
`define LED_ADDR_BITS 12

// display settings after reset, everything on
`define LED_RGB_RESET 3'b111
`define LED_BRIGHT_RESET 6'b111111

`endif

// File: src/led_ctrl_pkg.sv
package led_ctrl_pkg;

    // operations sent from the command decoder to the settings block and the line loader
    typedef enum logic [3:0] {
        // arg holds the channel index, 0 red, 1 green, 2 blue
        op_color_set,
        op_color_clear,
        // arg holds the bit index, 0 is the msb of the mask
        op_bright_toggle,
        op_bright_none,
        op_bright_all,
        // arg holds the row byte, the loader keeps the low bits
        op_line_begin,
        // arg holds one pixel data byte
        op_line_byte
    } cmd_op_t;

    // decoder state for the line command
    typedef enum logic [1:0] {
        // single character commands
        st_idle,
        // after L, waiting for the row byte
        st_wait_row,
        // pixel bytes go to the loader until line_done
        st_load
    } dec_state_t;

endpackage

// File: src/cmd_if.sv
// decoded command bus from the decoder to the settings block and the loader
interface cmd_if;

    // one cycle per command
    logic                  strobe;
    // valid while strobe is high
    led_ctrl_pkg::cmd_op_t op;
    logic [7:0]            arg;
    // loader reports the last byte of a line
    logic                  line_done;

    modport decoder (
        output strobe,
        output op,
        output arg,
        input  line_done
    );

    modport settings (
        input strobe,
        input op,
        input arg
    );

    modport loader (
        input  strobe,
        input  op,
        input  arg,
        output line_done
    );

endinterface

// File: src/uart_byte_rx.sv
`include "led_ctrl_config.svh"

module uart_byte_rx (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       busy
);
    localparam int TICK_BITS = `LED_UART_TICKS_WIDTH;
    localparam int TICKS     = `LED_UART_TICKS_PER_BIT;

    localparam logic [TICK_BITS-1:0] TICK_LAST = TICK_BITS'(TICKS - 1);
    // first wait ends in the middle of the start bit
    localparam logic [TICK_BITS-1:0] TICK_HALF = TICK_BITS'(TICKS / 2 - 1);

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic [TICK_BITS-1:0] tick_cnt;
    // 0 is the start bit, 1 to 8 data, 9 the stop bit
    logic [3:0]           bit_cnt;
    logic [7:0]           shift;
    logic                 bit_tick;
    logic                 data_sample;
    logic                 stop_sample;

    assign bit_tick    = busy && (tick_cnt == '0);
    assign data_sample = bit_tick && (bit_cnt != 4'd0) && (bit_cnt != 4'd9);
    assign stop_sample = bit_tick && (bit_cnt == 4'd9);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            // line idles high
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= 4'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;

            if (!busy) begin
                // falling edge on the synchronized line
                if (rx_prev && !rx_sync) begin
                    busy     <= 1'b1;
                    tick_cnt <= TICK_HALF;
                    bit_cnt  <= 4'd0;
                end
            end else if (tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else begin
                tick_cnt <= TICK_LAST;
                bit_cnt  <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0 && rx_sync) begin
                    // glitch, start bit gone by mid-bit
                    busy <= 1'b0;
                end else if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                    // bad stop bit drops the byte
                    rx_valid <= rx_sync;
                end
            end
        end
    end

    // lsb first
    always_ff @(posedge clk_in) begin
        if (data_sample) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (stop_sample && rx_sync) begin
            rx_byte <= shift;
        end
    end

endmodule

// File: src/command_decoder.sv
module command_decoder (
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    cmd_if.decoder     cmd
);
    led_ctrl_pkg::dec_state_t state;
    led_ctrl_pkg::dec_state_t state_next;
    logic                     emit;
    led_ctrl_pkg::cmd_op_t    op_next;
    logic [7:0]               arg_next;

    // channel index for the colour letters
    function automatic logic [7:0] color_index(input logic [7:0] c);
        case (c)
            "R", "r": return 8'd0;
            "G", "g": return 8'd1;
            default:  return 8'd2;
        endcase
    endfunction

    always_comb begin
        state_next = state;
        emit       = 1'b0;
        op_next    = led_ctrl_pkg::op_color_set;
        arg_next   = rx_byte;

        case (state)
            led_ctrl_pkg::st_idle: begin
                if (rx_valid) begin
                    emit = 1'b1;
                    case (rx_byte)
                        "R", "G", "B": begin
                            op_next  = led_ctrl_pkg::op_color_set;
                            arg_next = color_index(rx_byte);
                        end
                        "r", "g", "b": begin
                            op_next  = led_ctrl_pkg::op_color_clear;
                            arg_next = color_index(rx_byte);
                        end
                        "1", "2", "3", "4", "5", "6": begin
                            op_next  = led_ctrl_pkg::op_bright_toggle;
                            arg_next = rx_byte - "1";
                        end
                        "0": op_next = led_ctrl_pkg::op_bright_none;
                        "9": op_next = led_ctrl_pkg::op_bright_all;
                        "L": begin
                            // no command yet, the row byte follows
                            emit       = 1'b0;
                            state_next = led_ctrl_pkg::st_wait_row;
                        end
                        default: emit = 1'b0;
                    endcase
                end
            end
            led_ctrl_pkg::st_wait_row: begin
                // repeated L bytes keep waiting
                if (rx_valid && rx_byte != "L") begin
                    emit       = 1'b1;
                    op_next    = led_ctrl_pkg::op_line_begin;
                    state_next = led_ctrl_pkg::st_load;
                end
            end
            led_ctrl_pkg::st_load: begin
                if (rx_valid) begin
                    emit    = 1'b1;
                    op_next = led_ctrl_pkg::op_line_byte;
                end
                if (cmd.line_done) begin
                    state_next = led_ctrl_pkg::st_idle;
                end
            end
            default: state_next = led_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state      <= led_ctrl_pkg::st_idle;
            cmd.strobe <= 1'b0;
        end else begin
            state      <= state_next;
            cmd.strobe <= emit;
        end
    end

    always_ff @(posedge clk_in) begin
        if (emit) begin
            cmd.op  <= op_next;
            cmd.arg <= arg_next;
        end
    end

endmodule

// File: src/display_settings.sv
`include "led_ctrl_config.svh"

module display_settings (
    input  logic       clk_in,
    input  logic       reset,
    cmd_if.settings    cmd,
    output logic [2:0] rgb_enable,
    output logic [5:0] brightness_enable
);
    logic [1:0] color_bit;
    logic [2:0] bright_bit;

    assign color_bit = cmd.arg[1:0];
    // index 0 is the msb of the mask
    assign bright_bit = 3'd5 - cmd.arg[2:0];

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rgb_enable        <= `LED_RGB_RESET;
            brightness_enable <= `LED_BRIGHT_RESET;
        end else if (cmd.strobe) begin
            case (cmd.op)
                led_ctrl_pkg::op_color_set: begin
                    rgb_enable[color_bit] <= 1'b1;
                end
                led_ctrl_pkg::op_color_clear: begin
                    rgb_enable[color_bit] <= 1'b0;
                end
                led_ctrl_pkg::op_bright_toggle: begin
                    brightness_enable[bright_bit] <= ~brightness_enable[bright_bit];
                end
                led_ctrl_pkg::op_bright_none: begin
                    brightness_enable <= '0;
                end
                led_ctrl_pkg::op_bright_all: begin
                    brightness_enable <= '1;
                end
                // line ops belong to the loader
                default: begin
                end
            endcase
        end
    end

endmodule

// File: src/line_loader.sv
`include "led_ctrl_config.svh"

module line_loader (
    input  logic                      clk_in,
    input  logic                      reset,
    cmd_if.loader                     cmd,
    output logic                      wr_en,
    output logic [`LED_ADDR_BITS-1:0] wr_addr,
    output logic [7:0]                wr_data,
    output logic [7:0]                commands_done
);
    localparam int ROW_BITS = `LED_ROW_BITS;
    localparam int COL_BITS = `LED_ADDR_BITS - `LED_ROW_BITS;

    localparam logic [COL_BITS-1:0] COL_FIRST = COL_BITS'(`LED_COL_BYTES - 1);

    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] col;
    logic                line_start;
    logic                line_byte;

    assign line_start = cmd.strobe && (cmd.op == led_ctrl_pkg::op_line_begin);
    assign line_byte  = cmd.strobe && (cmd.op == led_ctrl_pkg::op_line_byte);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            row           <= '0;
            col           <= '0;
            wr_en         <= 1'b0;
            cmd.line_done <= 1'b0;
            commands_done <= 8'd0;
        end else begin
            wr_en         <= line_byte;
            cmd.line_done <= 1'b0;
            if (line_start) begin
                row <= cmd.arg[ROW_BITS-1:0];
                col <= COL_FIRST;
            end else if (line_byte) begin
                col <= col - 1'b1;
                if (col == '0) begin
                    // last byte of the line, count wraps at 256
                    cmd.line_done <= 1'b1;
                    commands_done <= commands_done + 8'd1;
                end
            end
        end
    end

    // column counts down and the middle bits are inverted,
    // so byte k of the line lands at column k xor 1
    always_ff @(posedge clk_in) begin
        if (line_byte) begin
            wr_addr <= {row, ~col[COL_BITS-1:1], col[0]};
            wr_data <= cmd.arg;
        end
    end

endmodule

// File: src/frame_buffer.sv
`include "led_ctrl_config.svh"

module frame_buffer #(
    parameter int ADDR_BITS = `LED_ADDR_BITS,
    parameter int DATA_BITS = 8
) (
    input  logic                 clk_in,
    input  logic                 wr_en,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  logic [DATA_BITS-1:0] wr_data,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output logic [DATA_BITS-1:0] rd_data
);
    localparam int DEPTH = 2 ** ADDR_BITS;

    logic [DATA_BITS-1:0] mem [DEPTH];

    // write port from the line loader
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read for the scan side
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: src/led_ctrl_top.sv
`include "led_ctrl_config.svh"

module led_ctrl_top (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      uart_rx,
    input  logic [`LED_ADDR_BITS-1:0] rd_addr,
    output logic                      rx_busy,
    output logic [2:0]                rgb_enable,
    output logic [5:0]                brightness_enable,
    output logic [7:0]                rd_data,
    output logic [7:0]                commands_done
);
    logic [7:0]                rx_byte;
    logic                      rx_valid;
    logic                      wr_en;
    logic [`LED_ADDR_BITS-1:0] wr_addr;
    logic [7:0]                wr_data;

    cmd_if cmd_bus ();

    uart_byte_rx uart_byte_rx_inst (
        .clk_in   (clk_in),
        .reset    (reset),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .busy     (rx_busy)
    );

    command_decoder command_decoder_inst (
        .clk_in   (clk_in),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cmd      (cmd_bus.decoder)
    );

    display_settings display_settings_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .cmd               (cmd_bus.settings),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    line_loader line_loader_inst (
        .clk_in        (clk_in),
        .reset         (reset),
        .cmd           (cmd_bus.loader),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .commands_done (commands_done)
    );

    frame_buffer frame_buffer_inst (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: tests/led_ctrl_tasks.svh
`ifndef LED_CTRL_TASKS_SVH
`define LED_CTRL_TASKS_SVH

// one clock and then the drive delay
task automatic step_cycle();
    @(posedge clk_in);
    #DRIVE_DELAY;
endtask

task automatic hold_bit();
    repeat (TICKS) step_cycle();
endtask

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", what);
endtask

task automatic check_value(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("Fail %s: expected %0d, actual %0d", test_name, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "value mismatch in %s", test_name);
    end
endtask

// 8N1 frame with the lsb first
task automatic send_byte(input logic [7:0] value);
    uart_rx = 1'b0;
    hold_bit();
    if (rx_busy !== 1'b1) begin
        report_failure("the uart receiver did not pick up the start bit");
    end
    for (int i = 0; i < 8; i++) begin
        uart_rx = value[i];
        hold_bit();
    end
    uart_rx = 1'b1;
    hold_bit();
    while (rx_busy) begin
        step_cycle();
    end
    repeat (4) step_cycle();
endtask

task automatic send_expect_settings(input string test_name, input logic [7:0] value,
                                    input logic [2:0] exp_rgb, input logic [5:0] exp_bright);
    send_byte(value);
    check_value(test_name, 32'(exp_rgb), 32'(rgb_enable));
    check_value(test_name, 32'(exp_bright), 32'(brightness_enable));
endtask

// row byte then one line of random pixels for the row in its low 5 bits
task automatic load_line(input logic [7:0] row_byte);
    logic [7:0] pixel;
    send_byte(row_byte);
    for (int k = 0; k < COLS; k++) begin
        pixel = 8'($random(seed));
        line_data[row_byte[4:0]][k] = pixel;
        send_byte(pixel);
    end
endtask

// byte k of row r sits at r * 128 + (k xor 1)
task automatic check_row(input string test_name, input int row);
    int addr;
    for (int k = 0; k < COLS; k++) begin
        addr    = row * COLS + (k ^ 1);
        rd_addr = 12'(addr);
        step_cycle();
        check_value(test_name, 32'(line_data[row][k]), 32'(rd_data));
    end
endtask

task automatic reset_state();
    check_value("reset_state rgb", 32'd7, 32'(rgb_enable));
    check_value("reset_state brightness", 32'd63, 32'(brightness_enable));
    check_value("reset_state count", 32'd0, 32'(commands_done));
endtask

task automatic color_cmds();
    send_expect_settings("color_cmds r", "r", 3'b110, 6'd63);
    send_expect_settings("color_cmds g", "g", 3'b100, 6'd63);
    send_expect_settings("color_cmds B", "B", 3'b100, 6'd63);
    send_expect_settings("color_cmds G", "G", 3'b110, 6'd63);
    send_expect_settings("color_cmds b", "b", 3'b010, 6'd63);
    // not a command
    send_expect_settings("color_cmds x", "x", 3'b010, 6'd63);
    // blue set shows only on a cleared channel
    send_expect_settings("color_cmds B after b", "B", 3'b110, 6'd63);
    send_expect_settings("color_cmds b again", "b", 3'b010, 6'd63);
endtask

task automatic brightness_cmds();
    send_expect_settings("brightness_cmds 0", "0", 3'b010, 6'b000000);
    send_expect_settings("brightness_cmds 1", "1", 3'b010, 6'b100000);
    send_expect_settings("brightness_cmds 6", "6", 3'b010, 6'b100001);
    send_expect_settings("brightness_cmds 9", "9", 3'b010, 6'b111111);
    // 3 is bit 3 of the mask
    send_expect_settings("brightness_cmds 3 first", "3", 3'b010, 6'b110111);
    send_expect_settings("brightness_cmds 3 second", "3", 3'b010, 6'b111111);
endtask

task automatic line_load();
    send_expect_settings("line_load L", "L", 3'b010, 6'd63);
    send_expect_settings("line_load repeated L", "L", 3'b010, 6'd63);
    load_line(8'd5);
    check_value("line_load count", 32'd1, 32'(commands_done));
    check_value("line_load rgb", 32'd2, 32'(rgb_enable));
    check_value("line_load brightness", 32'd63, 32'(brightness_enable));
    check_row("line_load row 5", 5);
endtask

task automatic line_then_commands();
    send_byte("L");
    // low 5 bits of 0xff give row 31
    load_line(8'hff);
    check_value("line_then_commands count", 32'd2, 32'(commands_done));
    send_expect_settings("line_then_commands R", "R", 3'b011, 6'd63);
    send_expect_settings("line_then_commands r", "r", 3'b010, 6'd63);
    check_value("line_then_commands count after colour", 32'd2, 32'(commands_done));
    check_row("line_then_commands row 5", 5);
    check_row("line_then_commands row 31", 31);
endtask

`endif

// File: tests/led_ctrl_tb.sv
`include "led_ctrl_config.svh"

module led_ctrl_tb;

    localparam int TICKS        = `LED_UART_TICKS_PER_BIT;
    localparam int COLS         = `LED_COL_BYTES;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;

    // colour 8, brightness 6, first line 131, second line with colour bytes 132
    localparam int TOTAL_BYTES    = 8 + 6 + 131 + 132;
    // each byte takes 10 bit times and the margin covers reset and the frame buffer reads
    localparam int TIMEOUT_CYCLES = (TOTAL_BYTES * 10 * TICKS * 3) / 2 + 2000;

    logic                      clk_in;
    logic                      reset;
    logic                      uart_rx;
    logic [`LED_ADDR_BITS-1:0] rd_addr;
    logic                      rx_busy;
    logic [2:0]                rgb_enable;
    logic [5:0]                brightness_enable;
    logic [7:0]                rd_data;
    logic [7:0]                commands_done;

    integer     seed;
    int         cycle_count = 0;
    // pixel bytes sent to each row by byte position
    logic [7:0] line_data [32][COLS];

    led_ctrl_top led_ctrl_top_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .uart_rx           (uart_rx),
        .rd_addr           (rd_addr),
        .rx_busy           (rx_busy),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_data           (rd_data),
        .commands_done     (commands_done)
    );

    `include "led_ctrl_tasks.svh"

    initial begin
        clk_in = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_in = ~clk_in;
        end
    end

    // run limit
    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout after %0d cycles, the test sequence did not complete",
                   cycle_count);
        end
    end

    initial begin
        reset   = 1'b1;
        uart_rx = 1'b1;
        rd_addr = '0;
        seed    = 1602;

        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (2) step_cycle();

        reset_state();
        color_cmds();
        brightness_cmds();
        line_load();
        line_then_commands();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+src
+incdir+tests
src/led_ctrl_pkg.sv
src/cmd_if.sv
src/uart_byte_rx.sv
src/command_decoder.sv
src/display_settings.sv
src/line_loader.sv
src/frame_buffer.sv
src/led_ctrl_top.sv
tests/led_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# the exit status is nonzero when the simulation ends in $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f files.f \
    --top-module led_ctrl_tb \
    -o led_ctrl_sim

./obj_dir/led_ctrl_sim
